//--- logic/stepper_spi_pkg.sv
/*
  Stepper SPI peripheral definitions.
  Bus width, the register map of the SPI block on the CPU memory bus,
  config register bit positions and the default transfer sizes.
*/
package stepper_spi_pkg;

  // cpu memory bus
  localparam int BUS_W = 32;

  // peripheral base address
  localparam logic [BUS_W-1:0] IO_BASE = 32'h1000_0000;

  // byte offsets from IO_BASE
  localparam logic [7:0] OFS_OUT_UPPER = 8'h00;
  localparam logic [7:0] OFS_OUT_LOWER = 8'h04;
  localparam logic [7:0] OFS_IN_UPPER  = 8'h08;
  localparam logic [7:0] OFS_IN_LOWER  = 8'h0c;
  localparam logic [7:0] OFS_CONFIG    = 8'h10;

  // config register layout
  localparam int CFG_SEND_BIT  = 0;
  localparam int CFG_READY_BIT = 1;
  localparam int CFG_DIV_LSB   = 2;

  // divider field width, half-period is div+1 clocks
  localparam int DIV_W_DEFAULT = 3;

  // address byte plus 32-bit data word
  localparam int FRAME_BITS_DEFAULT = 40;

endpackage

//--- logic/spi_ctrl_if.sv
/*
  Control interface between the register bank and the SPI engine.
  Carries the start strobe, outgoing frame and divider towards the
  engine, and busy, done and the received frame back.
*/
`timescale 1ns/1ps

interface spi_ctrl_if #(
  parameter int FRAME_BITS = stepper_spi_pkg::FRAME_BITS_DEFAULT,
  parameter int DIV_W      = stepper_spi_pkg::DIV_W_DEFAULT
);

  logic                  start;
  logic [FRAME_BITS-1:0] tx_frame;
  logic [DIV_W-1:0]      clk_div;
  logic                  busy;
  logic                  done;
  // valid while done is high
  logic [FRAME_BITS-1:0] rx_frame;

  modport regs (
    output start, tx_frame, clk_div,
    input  busy, done, rx_frame
  );

  modport engine (
    input  start, tx_frame, clk_div,
    output busy, done, rx_frame
  );

endinterface

//--- logic/io_register_bank.sv
/*
  SPI register bank.
  Decodes memory bus accesses to the five peripheral registers,
  applies byte-lane writes, answers every access with one ready pulse
  and turns a send write into a start strobe for the SPI engine.
*/
`timescale 1ns/1ps

module io_register_bank #(
  parameter int FRAME_BITS = stepper_spi_pkg::FRAME_BITS_DEFAULT,
  parameter int DIV_W      = stepper_spi_pkg::DIV_W_DEFAULT
) (
  input  logic                                  clk_25mhz,
  input  logic                                  rst_n,
  input  logic                                  mem_valid,
  input  logic [stepper_spi_pkg::BUS_W-1:0]     mem_addr,
  input  logic [stepper_spi_pkg::BUS_W-1:0]     mem_wdata,
  input  logic [stepper_spi_pkg::BUS_W/8-1:0]   mem_wstrb,
  output logic [stepper_spi_pkg::BUS_W-1:0]     mem_rdata,
  output logic                                  mem_ready,
  spi_ctrl_if.regs                              ctrl
);

  localparam int BUS_W   = stepper_spi_pkg::BUS_W;
  localparam int UPPER_W = FRAME_BITS - BUS_W;

  logic [UPPER_W-1:0] out_upper;
  logic [BUS_W-1:0]   out_lower;
  logic [UPPER_W-1:0] in_upper;
  logic [BUS_W-1:0]   in_lower;
  logic [DIV_W-1:0]   clk_div;

  logic access;
  logic wr;
  logic hit_out_upper;
  logic hit_out_lower;
  logic hit_in_upper;
  logic hit_in_lower;
  logic hit_cfg;
  logic engine_busy;
  logic send_req;
  logic [BUS_W-1:0] cfg_word;
  logic [BUS_W-1:0] rd_word;
  logic [BUS_W-1:0] upper_merged;
  logic [BUS_W-1:0] lower_merged;
  logic [BUS_W-1:0] cfg_merged;

  // replace the byte lanes selected by strb
  function automatic logic [BUS_W-1:0] merge_lanes(input logic [BUS_W-1:0] old_word,
                                                   input logic [BUS_W-1:0] new_word,
                                                   input logic [BUS_W/8-1:0] strb);
    logic [BUS_W-1:0] res;
    int i;
    res = old_word;
    for (i = 0; i < BUS_W / 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

  // word match, low address bits ignored
  function automatic logic reg_hit(input logic [BUS_W-1:0] addr, input logic [7:0] ofs);
    logic [BUS_W-1:0] target;
    target = stepper_spi_pkg::IO_BASE + BUS_W'(ofs);
    return addr[BUS_W-1:2] == target[BUS_W-1:2];
  endfunction

  // one access per valid, ready pulse blocks a repeat
  assign access = mem_valid && !mem_ready;
  assign wr     = access && (|mem_wstrb);

  assign hit_out_upper = reg_hit(mem_addr, stepper_spi_pkg::OFS_OUT_UPPER);
  assign hit_out_lower = reg_hit(mem_addr, stepper_spi_pkg::OFS_OUT_LOWER);
  assign hit_in_upper  = reg_hit(mem_addr, stepper_spi_pkg::OFS_IN_UPPER);
  assign hit_in_lower  = reg_hit(mem_addr, stepper_spi_pkg::OFS_IN_LOWER);
  assign hit_cfg       = reg_hit(mem_addr, stepper_spi_pkg::OFS_CONFIG);

  // start already issued counts as busy
  assign engine_busy = ctrl.busy || ctrl.start;
  assign send_req    = wr && hit_cfg && mem_wstrb[stepper_spi_pkg::CFG_SEND_BIT / 8] &&
                       mem_wdata[stepper_spi_pkg::CFG_SEND_BIT];

  always_comb begin
    cfg_word = '0;
    cfg_word[stepper_spi_pkg::CFG_READY_BIT] = !engine_busy;
    cfg_word[stepper_spi_pkg::CFG_DIV_LSB +: DIV_W] = clk_div;
  end

  assign upper_merged = merge_lanes(BUS_W'(out_upper), mem_wdata, mem_wstrb);
  assign lower_merged = merge_lanes(out_lower, mem_wdata, mem_wstrb);
  assign cfg_merged   = merge_lanes(cfg_word, mem_wdata, mem_wstrb);

  // read mux, unmapped addresses return 0
  always_comb begin
    if (hit_out_upper) begin
      rd_word = BUS_W'(out_upper);
    end else if (hit_out_lower) begin
      rd_word = out_lower;
    end else if (hit_in_upper) begin
      rd_word = BUS_W'(in_upper);
    end else if (hit_in_lower) begin
      rd_word = in_lower;
    end else if (hit_cfg) begin
      rd_word = cfg_word;
    end else begin
      rd_word = '0;
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      mem_ready  <= 1'b0;
      mem_rdata  <= '0;
      ctrl.start <= 1'b0;
      out_upper  <= '0;
      out_lower  <= '0;
      in_upper   <= '0;
      in_lower   <= '0;
      clk_div    <= '0;
    end else begin
      mem_ready  <= access;
      mem_rdata  <= access ? rd_word : '0;
      ctrl.start <= send_req && !engine_busy;
      if (wr && hit_out_upper) begin
        out_upper <= upper_merged[UPPER_W-1:0];
      end
      if (wr && hit_out_lower) begin
        out_lower <= lower_merged;
      end
      // divider frozen while a frame is on the wire
      if (wr && hit_cfg && !engine_busy) begin
        clk_div <= cfg_merged[stepper_spi_pkg::CFG_DIV_LSB +: DIV_W];
      end
      if (ctrl.done) begin
        in_upper <= ctrl.rx_frame[FRAME_BITS-1 -: UPPER_W];
        in_lower <= ctrl.rx_frame[BUS_W-1:0];
      end
    end
  end

  assign ctrl.tx_frame = {out_upper, out_lower};
  assign ctrl.clk_div  = clk_div;

endmodule

//--- logic/spi_sequencer.sv
/*
  SPI transfer sequencer.
  Mode 3 state machine: lead half-period, FRAME_BITS low/high SCK
  pairs, trail half-period. Drives chip select and SCK, and issues
  the load, shift and sample strobes for the frame shifter.
*/
`timescale 1ns/1ps

module spi_sequencer #(
  parameter int FRAME_BITS = stepper_spi_pkg::FRAME_BITS_DEFAULT
) (
  input  logic                  clk_25mhz,
  input  logic                  rst_n,
  spi_ctrl_if.engine            ctrl,
  input  logic                  tick,
  output logic                  run,
  output logic                  load,
  output logic                  shift,
  output logic                  sample,
  input  logic [FRAME_BITS-1:0] rx_frame_in,
  output logic                  sck,
  output logic                  cs_n
);

  localparam int CNT_W = (FRAME_BITS > 1) ? $clog2(FRAME_BITS) : 1;

  typedef enum logic [2:0] {
    st_idle,
    st_lead,
    st_sck_lo,
    st_sck_hi,
    st_trail
  } state_t;

  state_t           state;
  state_t           state_nxt;
  logic [CNT_W-1:0] bit_cnt;
  logic             last_bit;

  assign last_bit = (bit_cnt == CNT_W'(FRAME_BITS - 1));

  // one state step per half-period tick
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (ctrl.start) begin
          state_nxt = st_lead;
        end
      end
      st_lead: begin
        if (tick) begin
          state_nxt = st_sck_lo;
        end
      end
      st_sck_lo: begin
        if (tick) begin
          state_nxt = st_sck_hi;
        end
      end
      st_sck_hi: begin
        if (tick) begin
          state_nxt = last_bit ? st_trail : st_sck_lo;
        end
      end
      st_trail: begin
        if (tick) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  assign run    = (state != st_idle);
  assign load   = (state == st_idle) && ctrl.start;
  // rising SCK edge
  assign sample = (state == st_sck_lo) && tick;
  // falling SCK edge, first bit is already on mosi after load
  assign shift  = (state == st_sck_hi) && tick && !last_bit;

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      state     <= st_idle;
      bit_cnt   <= '0;
      sck       <= 1'b1;
      cs_n      <= 1'b1;
      ctrl.busy <= 1'b0;
      ctrl.done <= 1'b0;
    end else begin
      state     <= state_nxt;
      sck       <= (state_nxt != st_sck_lo);
      cs_n      <= (state_nxt == st_idle);
      ctrl.busy <= (state_nxt != st_idle);
      ctrl.done <= (state == st_trail) && tick;
      if (state == st_lead) begin
        bit_cnt <= '0;
      end else if (shift) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // shifter holds the full frame once trail ends
  assign ctrl.rx_frame = rx_frame_in;

endmodule

//--- logic/sck_timer.sv
/*
  SCK half-period timer.
  Pulses tick every clk_div+1 clock cycles while run is high and
  restarts from zero whenever run drops.
*/
`timescale 1ns/1ps

module sck_timer #(
  parameter int DIV_W = stepper_spi_pkg::DIV_W_DEFAULT
) (
  input  logic             clk_25mhz,
  input  logic             rst_n,
  input  logic             run,
  input  logic [DIV_W-1:0] clk_div,
  output logic             tick
);

  logic [DIV_W-1:0] count;

  // last cycle of the current half-period
  assign tick = run && (count == clk_div);

  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!run || tick) begin
      // idle or wrap, next half-period starts full length
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

//--- logic/frame_shifter.sv
/*
  SPI frame shifter.
  Loads the outgoing frame and presents its top bit on MOSI, moving
  one place per shift. MISO bits enter a separate receive register
  on each sample, most significant bit first.
*/
`timescale 1ns/1ps

module frame_shifter #(
  parameter int FRAME_BITS = stepper_spi_pkg::FRAME_BITS_DEFAULT
) (
  input  logic                  clk_25mhz,
  input  logic                  rst_n,
  input  logic                  load,
  input  logic [FRAME_BITS-1:0] tx_frame,
  input  logic                  shift,
  input  logic                  sample,
  input  logic                  miso,
  output logic                  mosi,
  output logic [FRAME_BITS-1:0] rx_frame
);

  logic [FRAME_BITS-1:0] tx_shift;
  logic [FRAME_BITS-1:0] rx_shift;

  // transmit side
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      tx_shift <= '0;
    end else if (load) begin
      tx_shift <= tx_frame;
    end else if (shift) begin
      tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
    end
  end

  // receive side, after FRAME_BITS samples the whole frame is in
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      rx_shift <= '0;
    end else if (sample) begin
      rx_shift <= {rx_shift[FRAME_BITS-2:0], miso};
    end
  end

  assign mosi     = tx_shift[FRAME_BITS-1];
  assign rx_frame = rx_shift;

endmodule

//--- logic/stepper_spi_top.sv
/*
  Stepper SPI peripheral top level.
  Connects the CPU memory bus and the SPI pins to the register bank,
  the transfer sequencer, the SCK timer and the frame shifter.
*/
`timescale 1ns/1ps

module stepper_spi_top #(
  parameter int FRAME_BITS = stepper_spi_pkg::FRAME_BITS_DEFAULT,
  parameter int DIV_W      = stepper_spi_pkg::DIV_W_DEFAULT
) (
  input  logic                                clk_25mhz,
  input  logic                                rst_n,
  input  logic                                mem_valid,
  input  logic [stepper_spi_pkg::BUS_W-1:0]   mem_addr,
  input  logic [stepper_spi_pkg::BUS_W-1:0]   mem_wdata,
  input  logic [stepper_spi_pkg::BUS_W/8-1:0] mem_wstrb,
  output logic [stepper_spi_pkg::BUS_W-1:0]   mem_rdata,
  output logic                                mem_ready,
  input  logic                                miso,
  output logic                                sck,
  output logic                                mosi,
  output logic                                cs_n
);

  logic                  run;
  logic                  tick;
  logic                  load;
  logic                  shift;
  logic                  sample;
  logic [FRAME_BITS-1:0] rx_frame;

  spi_ctrl_if #(.FRAME_BITS(FRAME_BITS), .DIV_W(DIV_W)) ctrl_if ();

  io_register_bank #(.FRAME_BITS(FRAME_BITS), .DIV_W(DIV_W)) regs_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .ctrl      (ctrl_if.regs)
  );

  spi_sequencer #(.FRAME_BITS(FRAME_BITS)) seq_i (
    .clk_25mhz   (clk_25mhz),
    .rst_n       (rst_n),
    .ctrl        (ctrl_if.engine),
    .tick        (tick),
    .run         (run),
    .load        (load),
    .shift       (shift),
    .sample      (sample),
    .rx_frame_in (rx_frame),
    .sck         (sck),
    .cs_n        (cs_n)
  );

  sck_timer #(.DIV_W(DIV_W)) timer_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .run       (run),
    .clk_div   (ctrl_if.clk_div),
    .tick      (tick)
  );

  frame_shifter #(.FRAME_BITS(FRAME_BITS)) shifter_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .load      (load),
    .tx_frame  (ctrl_if.tx_frame),
    .shift     (shift),
    .sample    (sample),
    .miso      (miso),
    .mosi      (mosi),
    .rx_frame  (rx_frame)
  );

endmodule

//--- tests/clk_gen.sv
/*
  Testbench clock and reset source.
  25 MHz clock, synchronous reset held low for the first cycles.
*/
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_25mhz,
  output logic rst_n
);

  initial begin
    clk_25mhz = 1'b0;
    forever #(PERIOD_NS / 2) clk_25mhz = ~clk_25mhz;
  end

  // release on a falling edge, clear of the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_25mhz);
    @(negedge clk_25mhz);
    rst_n = 1'b1;
  end

endmodule

//--- tests/stepper_spi_tb.sv
/*
  Testbench for the stepper SPI peripheral.
  Acts as bus master, models the stepper driver chip on the SPI pins
  and checks registers, frames, ready flag and SCK timing against a
  reference model of the register map.
*/
`timescale 1ns/1ps

module stepper_spi_tb;

  localparam int FRAME_BITS  = stepper_spi_pkg::FRAME_BITS_DEFAULT;
  localparam int DIV_W       = stepper_spi_pkg::DIV_W_DEFAULT;
  localparam int UPPER_W     = FRAME_BITS - 32;
  localparam int CLK_NS      = 40;
  localparam int NUM_XFERS   = 32;
  localparam int BUS_TIMEOUT = 8;
  // longest transfer uses divider 7
  localparam int XFER_CYCLES = (2 * FRAME_BITS + 2) * 8 + 1;
  localparam int WATCHDOG_CYCLES = 40 * XFER_CYCLES + 20000;
  localparam logic [31:0] BASE = stepper_spi_pkg::IO_BASE;

  logic        clk_25mhz;
  logic        rst_n;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic        miso;
  logic        sck;
  logic        mosi;
  logic        cs_n;

  // reference model of the registers
  logic [UPPER_W-1:0] m_out_upper;
  logic [31:0]        m_out_lower;
  logic [UPPER_W-1:0] m_in_upper;
  logic [31:0]        m_in_lower;
  logic [DIV_W-1:0]   m_div;

  // driver chip model state
  logic [FRAME_BITS-1:0] drv_resp;
  logic [FRAME_BITS-1:0] drv_cap;
  logic [FRAME_BITS-1:0] exp_tx;
  logic                  in_xfer;
  int                    cap_cnt;
  int                    cs_falls;
  int                    cs_rises;
  int                    exp_falls;
  int                    xfer_div;
  time                   last_edge;
  int                    n;

  clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(5)) clk_gen_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n)
  );

  stepper_spi_top #(.FRAME_BITS(FRAME_BITS), .DIV_W(DIV_W)) dut_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n)
  );

  task automatic fail_stop();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      fail_stop();
    end
  endtask

  function automatic logic [31:0] reg_addr(input logic [7:0] ofs);
    return BASE + 32'(ofs);
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  function automatic logic [31:0] cfg_value(input logic ready);
    return (32'(m_div) << stepper_spi_pkg::CFG_DIV_LSB) |
           (32'(ready) << stepper_spi_pkg::CFG_READY_BIT);
  endfunction

  // one bus access from one falling edge to a later one
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata);
    int waited;
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = strb;
    waited    = 0;
    @(negedge clk_25mhz);
    while (mem_ready !== 1'b1 && waited < BUS_TIMEOUT) begin
      check_val("mem_rdata", mem_rdata, 64'h0);
      waited++;
      @(negedge clk_25mhz);
    end
    assert (mem_ready === 1'b1) else begin
      $display("bus access to 0x%08h got no mem_ready within %0d cycles", addr, BUS_TIMEOUT);
      fail_stop();
    end
    rdata     = mem_rdata;
    mem_valid = 1'b0;
    mem_wstrb = 4'h0;
    @(negedge clk_25mhz);
    // single ready pulse and rdata back to 0
    check_val("mem_ready", mem_ready, 64'h0);
    check_val("mem_rdata", mem_rdata, 64'h0);
  endtask

  task automatic check_all_regs();
    logic [31:0] rd;
    bus_access(reg_addr(stepper_spi_pkg::OFS_OUT_UPPER), 32'h0, 4'h0, rd);
    check_val("out_upper", rd, 64'(m_out_upper));
    bus_access(reg_addr(stepper_spi_pkg::OFS_OUT_LOWER), 32'h0, 4'h0, rd);
    check_val("out_lower", rd, 64'(m_out_lower));
    bus_access(reg_addr(stepper_spi_pkg::OFS_IN_UPPER), 32'h0, 4'h0, rd);
    check_val("in_upper", rd, 64'(m_in_upper));
    bus_access(reg_addr(stepper_spi_pkg::OFS_IN_LOWER), 32'h0, 4'h0, rd);
    check_val("in_lower", rd, 64'(m_in_lower));
    bus_access(reg_addr(stepper_spi_pkg::OFS_CONFIG), 32'h0, 4'h0, rd);
    check_val("config", rd, 64'(cfg_value(1'b1)));
  endtask

  // random byte-lane writes with the send bit kept clear
  task automatic reg_write_test(input int count);
    logic [31:0] wdata;
    logic [31:0] mask;
    logic [31:0] rd;
    logic [7:0]  ofs;
    logic [3:0]  strb;
    int          sel;
    int          i;
    for (i = 0; i < count; i++) begin
      sel   = $urandom_range(0, 4);
      wdata = $urandom;
      strb  = 4'($urandom_range(1, 15));
      mask  = lane_mask(strb);
      case (sel)
        0: ofs = stepper_spi_pkg::OFS_OUT_UPPER;
        1: ofs = stepper_spi_pkg::OFS_OUT_LOWER;
        2: ofs = stepper_spi_pkg::OFS_IN_UPPER;
        3: ofs = stepper_spi_pkg::OFS_IN_LOWER;
        default: ofs = stepper_spi_pkg::OFS_CONFIG;
      endcase
      wdata[stepper_spi_pkg::CFG_SEND_BIT] = (sel == 4) ? 1'b0 : wdata[0];
      bus_access(reg_addr(ofs), wdata, strb, rd);
      case (sel)
        0: m_out_upper = UPPER_W'((32'(m_out_upper) & ~mask) | (wdata & mask));
        1: m_out_lower = (m_out_lower & ~mask) | (wdata & mask);
        4: if (strb[0]) m_div = wdata[stepper_spi_pkg::CFG_DIV_LSB +: DIV_W];
        default: m_div = m_div;
      endcase
      check_all_regs();
    end
  endtask

  task automatic unmapped_test(input int count);
    logic [31:0] addr;
    logic [31:0] rd;
    int          i;
    for (i = 0; i < count; i++) begin
      if (i % 2 == 0) begin
        addr = BASE + 32'h14 + 32'(4 * $urandom_range(0, 59));
      end else begin
        addr = $urandom;
        if (addr[31:5] == BASE[31:5]) addr[31] = ~addr[31];
      end
      bus_access(addr, $urandom, 4'($urandom_range(0, 15)), rd);
      check_val("mem_rdata", rd, 64'h0);
    end
    check_all_regs();
  endtask

  task automatic run_transfer(input logic [DIV_W-1:0] div, input logic resend);
    logic [31:0] word;
    logic [31:0] rd;
    int          polls;
    word = $urandom;
    bus_access(reg_addr(stepper_spi_pkg::OFS_OUT_UPPER), word, 4'hf, rd);
    m_out_upper = word[UPPER_W-1:0];
    word = $urandom;
    bus_access(reg_addr(stepper_spi_pkg::OFS_OUT_LOWER), word, 4'hf, rd);
    m_out_lower = word;
    word = $urandom;
    drv_resp = {word[UPPER_W-1:0], 32'($urandom)};
    exp_tx   = {m_out_upper, m_out_lower};
    xfer_div = int'(div);
    m_div    = div;
    exp_falls++;
    word = $urandom;
    word[stepper_spi_pkg::CFG_SEND_BIT] = 1'b1;
    word[stepper_spi_pkg::CFG_DIV_LSB +: DIV_W] = div;
    bus_access(reg_addr(stepper_spi_pkg::OFS_CONFIG), word, 4'hf, rd);
    bus_access(reg_addr(stepper_spi_pkg::OFS_CONFIG), 32'h0, 4'h0, rd);
    check_val("config", rd, 64'(cfg_value(1'b0)));
    if (resend) begin
      // new frame and divider must not reach the wire
      word = $urandom;
      bus_access(reg_addr(stepper_spi_pkg::OFS_OUT_LOWER), word, 4'hf, rd);
      m_out_lower = word;
      word = $urandom | 32'h1;
      bus_access(reg_addr(stepper_spi_pkg::OFS_CONFIG), word, 4'hf, rd);
    end
    rd    = '0;
    polls = 0;
    while (!rd[stepper_spi_pkg::CFG_READY_BIT] && polls < XFER_CYCLES) begin
      bus_access(reg_addr(stepper_spi_pkg::OFS_CONFIG), 32'h0, 4'h0, rd);
      if (!rd[stepper_spi_pkg::CFG_READY_BIT]) check_val("config", rd, 64'(cfg_value(1'b0)));
      polls++;
    end
    assert (rd[stepper_spi_pkg::CFG_READY_BIT]) else begin
      $display("ready bit still 0 after %0d status reads", polls);
      fail_stop();
    end
    check_val("config", rd, 64'(cfg_value(1'b1)));
    check_val("cs_n", cs_n, 64'h1);
    check_val("cs_n falling edges", cs_falls, exp_falls);
    check_val("cs_n rising edges", cs_rises, exp_falls);
    m_in_upper = drv_resp[FRAME_BITS-1 -: UPPER_W];
    m_in_lower = drv_resp[31:0];
    check_all_regs();
  endtask

  // pin edges inside a transfer lie whole half-periods apart
  task automatic check_edge_gap(input int halves);
    check_val("pin edge gap ns", 64'($time - last_edge),
              64'(halves * (xfer_div + 1) * CLK_NS));
    last_edge = $time;
  endtask

  // driver chip captures on rising sck and updates miso after falling sck
  always @(negedge cs_n) begin
    in_xfer   = 1'b1;
    cap_cnt   = 0;
    drv_cap   = '0;
    last_edge = $time;
    cs_falls++;
    @(negedge clk_25mhz);
    miso = drv_resp[FRAME_BITS-1];
  end

  // last high SCK half-period and the trail half-period before cs_n rises
  always @(posedge cs_n) begin
    if (in_xfer) begin
      in_xfer = 1'b0;
      cs_rises++;
      check_edge_gap(2);
      check_val("mosi bit count", cap_cnt, FRAME_BITS);
      check_val("mosi frame", drv_cap, exp_tx);
    end
  end

  always @(posedge sck) begin
    if (in_xfer) begin
      check_edge_gap(1);
      drv_cap = {drv_cap[FRAME_BITS-2:0], mosi};
      cap_cnt++;
    end
  end

  always @(negedge sck) begin
    if (in_xfer) begin
      check_edge_gap(1);
      if (cap_cnt > 0 && cap_cnt < FRAME_BITS) begin
        @(negedge clk_25mhz);
        miso = drv_resp[FRAME_BITS-1-cap_cnt];
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_25mhz);
    $display("watchdog expired, run did not finish within %0d cycles", WATCHDOG_CYCLES);
    fail_stop();
  end

  initial begin
    void'($urandom(45739));
    mem_valid   = 1'b0;
    mem_addr    = '0;
    mem_wdata   = '0;
    mem_wstrb   = '0;
    miso        = 1'b0;
    in_xfer     = 1'b0;
    m_out_upper = '0;
    m_out_lower = '0;
    m_in_upper  = '0;
    m_in_lower  = '0;
    m_div       = '0;
    drv_resp    = '0;
    exp_tx      = '0;
    cs_falls    = 0;
    cs_rises    = 0;
    exp_falls   = 0;
    xfer_div    = 0;
    wait (rst_n === 1'b1);
    check_val("cs_n", cs_n, 64'h1);
    check_val("sck", sck, 64'h1);
    check_val("mosi", mosi, 64'h0);
    check_val("mem_ready", mem_ready, 64'h0);
    check_all_regs();
    reg_write_test(60);
    unmapped_test(24);
    // both divider extremes come before the random ones
    for (n = 0; n < NUM_XFERS; n++) begin
      if (n == 0) run_transfer('0, 1'b0);
      else if (n == 1) run_transfer('1, 1'b1);
      else run_transfer(DIV_W'($urandom_range(0, 7)), (n % 4 == 3));
    end
    reg_write_test(10);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- filelist.f
logic/stepper_spi_pkg.sv
logic/spi_ctrl_if.sv
logic/io_register_bank.sv
logic/spi_sequencer.sv
logic/sck_timer.sv
logic/frame_shifter.sv
logic/stepper_spi_top.sv
tests/clk_gen.sv
tests/stepper_spi_tb.sv
